// ==== rtl/xbus_pkg.sv ====
/*
 * shared types for the spi register bus core
 * byte, word and register index vectors, bridge fsm states
 * idle byte and audio register indices
 */
`default_nettype none

package xbus_pkg;

    typedef logic [7:0]  byte_t;        // spi byte, bus data
    typedef logic [15:0] word_t;        // one register
    typedef logic [3:0]  reg_num_t;     // register index

    typedef enum logic {
        BR_CMD  = 1'b0,                 // waiting for command byte
        BR_DATA = 1'b1                  // waiting for data byte
    } bridge_state_t;

    // shifted out on CIPO while the command byte comes in
    localparam byte_t SPI_IDLE_BYTE = 8'hCB;

    // audio duty registers, low byte is the pwm level
    localparam reg_num_t REG_AUDIO_L = 4'd14;
    localparam reg_num_t REG_AUDIO_R = 4'd15;

endpackage

`default_nettype wire

// ==== rtl/reset_stretch.sv ====
/*
 * reset stretcher with two-flop release synchronizer
 * holds reset for RESET_CYCLES after release, drives ready level
 */
`default_nettype none
`timescale 1ns/1ps

module reset_stretch #(
    parameter int RESET_CYCLES = 16             // cycles after sync release
) (
    input  wire  pclk,
    input  wire  rst_n_i,                       // board reset, async low
    output logic reset_o,                       // internal reset, high active
    output logic ready_o                        // status led level
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [1:0]       release_sync;             // release synchronizer
    logic [CNT_W-1:0] count;                    // stretch counter

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            release_sync <= 2'b00;
            count        <= '0;
            reset_o      <= 1'b1;
        end else begin
            release_sync <= {release_sync[0], 1'b1};
            if (release_sync[1] && reset_o) begin   // count only once released
                if (count == CNT_W'(RESET_CYCLES - 1)) begin
                    reset_o <= 1'b0;                // stretch done
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    assign ready_o = ~reset_o;                  // high when out of reset

endmodule

`default_nettype wire

// ==== rtl/spi_target.sv ====
/*
 * mode-0 spi peripheral, oversampled in the pclk domain
 * byte receive strobe, transmit load strobe, msb-first CIPO
 */
`default_nettype none
`timescale 1ns/1ps

module spi_target import xbus_pkg::*; (
    input  wire   pclk,
    input  wire   reset_i,
    input  wire   spi_sck_i,                    // host clock, at most pclk/8
    input  wire   spi_copi_i,                   // host data in
    input  wire   spi_cs_n_i,                   // host select, low active
    input  byte_t transmit_byte_i,              // byte for next load
    output logic  spi_cipo_o,                   // data to host
    output logic  select_o,                     // synced select level
    output logic  receive_strobe_o,             // one pulse per byte
    output byte_t receive_byte_o,               // valid with receive strobe
    output logic  transmit_strobe_o             // load pulse for transmit_byte_i
);

    logic [1:0] sck_sync;                       // two-flop synchronizers
    logic [1:0] copi_sync;
    logic [1:0] cs_sync;
    logic       sck_prev;                       // for edge detect
    logic       select_prev;
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_count;                      // wraps every byte
    byte_t      rx_shift;
    byte_t      tx_shift;

    always_ff @(posedge pclk or posedge reset_i) begin
        if (reset_i) begin
            sck_sync    <= 2'b00;
            copi_sync   <= 2'b00;
            cs_sync     <= 2'b11;               // idle deselected
            sck_prev    <= 1'b0;
            select_prev <= 1'b0;
        end else begin
            sck_sync    <= {sck_sync[0], spi_sck_i};
            copi_sync   <= {copi_sync[0], spi_copi_i};
            cs_sync     <= {cs_sync[0], spi_cs_n_i};
            sck_prev    <= sck_sync[1];
            select_prev <= select_o;
        end
    end

    assign select_o       = ~cs_sync[1];
    assign sck_rise       = sck_sync[1] & ~sck_prev;
    assign sck_fall       = ~sck_sync[1] & sck_prev;
    assign spi_cipo_o     = tx_shift[7];        // msb first
    assign receive_byte_o = rx_shift;           // full byte during strobe

    always_ff @(posedge pclk or posedge reset_i) begin
        if (reset_i) begin
            receive_strobe_o  <= 1'b0;
            transmit_strobe_o <= 1'b0;
        end else begin
            receive_strobe_o  <= select_o & sck_rise & (bit_count == 3'd7);
            // load on select rise and one cycle after each received byte
            transmit_strobe_o <= (select_o & ~select_prev) | receive_strobe_o;
        end
    end

    always_ff @(posedge pclk or posedge reset_i) begin
        if (reset_i) begin
            bit_count <= 3'd0;
            rx_shift  <= '0;
            tx_shift  <= '0;
        end else if (!select_o) begin           // deselect clears the frame
            bit_count <= 3'd0;
            rx_shift  <= '0;
            tx_shift  <= '0;
        end else begin
            if (sck_rise) begin
                rx_shift  <= {rx_shift[6:0], copi_sync[1]};
                bit_count <= bit_count + 3'd1;
            end
            if (transmit_strobe_o) begin
                tx_shift <= transmit_byte_i;
            end else if (sck_fall && bit_count != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};  // byte boundary keeps loaded msb
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/spi_bus_bridge.sv ====
/*
 * two-byte spi frame to register bus cycle
 * command and data latches, bus strobe, transmit byte select
 */
`default_nettype none
`timescale 1ns/1ps

module spi_bus_bridge import xbus_pkg::*; (
    input  wire      pclk,
    input  wire      reset_i,
    input  wire      select_i,                  // frame active
    input  wire      receive_strobe_i,
    input  byte_t    receive_byte_i,
    input  byte_t    bus_rdata_i,               // read byte from register file
    output byte_t    transmit_byte_o,           // next byte to host
    output logic     bus_cs_o,                  // one-cycle bus strobe
    output logic     bus_wr_o,
    output logic     bus_bytesel_o,             // 0 high byte, 1 low byte
    output reg_num_t bus_reg_num_o,
    output byte_t    bus_wdata_o
);

    bridge_state_t state;
    byte_t         cmd_byte;                    // W . . BS R3 R2 R1 R0
    byte_t         data_byte;

    always_ff @(posedge pclk or posedge reset_i) begin
        if (reset_i) begin
            state     <= BR_CMD;
            cmd_byte  <= '0;
            data_byte <= '0;
            bus_cs_o  <= 1'b0;
        end else if (!select_i) begin           // aborted or finished frame
            state    <= BR_CMD;
            bus_cs_o <= 1'b0;
        end else begin
            bus_cs_o <= 1'b0;
            if (receive_strobe_i) begin
                if (state == BR_CMD) begin
                    cmd_byte <= receive_byte_i;
                    state    <= BR_DATA;
                end else begin
                    data_byte <= receive_byte_i;
                    bus_cs_o  <= 1'b1;          // bus cycle in next cycle
                    state     <= BR_CMD;
                end
            end
        end
    end

    assign bus_wr_o      = cmd_byte[7];
    assign bus_bytesel_o = cmd_byte[4];
    assign bus_reg_num_o = cmd_byte[3:0];
    assign bus_wdata_o   = data_byte;

    // register byte once the command is known, idle byte otherwise
    assign transmit_byte_o = (state == BR_DATA) ? bus_rdata_i : SPI_IDLE_BYTE;

endmodule

`default_nettype wire

// ==== rtl/xbus_regs.sv ====
/*
 * register file of sixteen 16-bit words
 * byte-lane writes, combinational read mux, audio level taps
 */
`default_nettype none
`timescale 1ns/1ps

module xbus_regs import xbus_pkg::*; (
    input  wire      pclk,
    input  wire      reset_i,
    input  wire      bus_cs_i,                  // one-cycle strobe
    input  wire      bus_wr_i,
    input  wire      bus_bytesel_i,             // 0 high byte, 1 low byte
    input  reg_num_t bus_reg_num_i,
    input  byte_t    bus_wdata_i,
    output byte_t    bus_rdata_o,
    output byte_t    audio_l_level_o,
    output byte_t    audio_r_level_o
);

    word_t regs [16];
    word_t rd_word;

    always_ff @(posedge pclk or posedge reset_i) begin
        if (reset_i) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (bus_cs_i && bus_wr_i) begin
            if (bus_bytesel_i) begin
                regs[bus_reg_num_i][7:0]  <= bus_wdata_i;   // low lane
            end else begin
                regs[bus_reg_num_i][15:8] <= bus_wdata_i;   // high lane
            end
        end
    end

    assign rd_word     = regs[bus_reg_num_i];
    assign bus_rdata_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

    // pwm duty from low bytes
    assign audio_l_level_o = regs[REG_AUDIO_L][7:0];
    assign audio_r_level_o = regs[REG_AUDIO_R][7:0];

endmodule

`default_nettype wire

// ==== rtl/audio_pwm.sv ====
/*
 * two-channel 8-bit audio pwm
 * shared ramp counter, registered compare outputs
 */
`default_nettype none
`timescale 1ns/1ps

module audio_pwm import xbus_pkg::*; (
    input  wire   pclk,
    input  wire   reset_i,
    input  byte_t level_l_i,                    // high cycles per 256
    input  byte_t level_r_i,
    output logic  audio_l_o,
    output logic  audio_r_o
);

    byte_t ramp;                                // free-running period counter

    always_ff @(posedge pclk or posedge reset_i) begin
        if (reset_i) begin
            ramp      <= '0;
            audio_l_o <= 1'b0;
            audio_r_o <= 1'b0;
        end else begin
            ramp      <= ramp + 8'd1;
            audio_l_o <= (ramp < level_l_i);    // level 0 stays low
            audio_r_o <= (ramp < level_r_i);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xbus_spi_top.sv ====
/*
 * spi register bus core top level
 * reset stretcher, spi target, bridge, register file, audio pwm
 */
`default_nettype none
`timescale 1ns/1ps

module xbus_spi_top import xbus_pkg::*; #(
    parameter int RESET_CYCLES = 16             // reset stretch length
) (
    input  wire  pclk,
    input  wire  rst_n_i,                       // board reset, low active
    input  wire  spi_sck_i,
    input  wire  spi_copi_i,
    input  wire  spi_cs_n_i,
    output logic spi_cipo_o,
    output logic audio_l_o,
    output logic audio_r_o,
    output logic ready_o                        // high out of reset
);

    logic     reset;                            // stretched, high active
    logic     spi_select;
    logic     spi_receive_strobe;
    byte_t    spi_receive_byte;
    byte_t    spi_transmit_byte;
    logic     bus_cs;
    logic     bus_wr;
    logic     bus_bytesel;
    reg_num_t bus_reg_num;
    byte_t    bus_wdata;
    byte_t    bus_rdata;
    byte_t    audio_l_level;
    byte_t    audio_r_level;

    reset_stretch #(
        .RESET_CYCLES(RESET_CYCLES)
    ) i_reset_stretch (
        .pclk(pclk), .rst_n_i(rst_n_i), .reset_o(reset), .ready_o(ready_o)
    );

    spi_target i_spi_target (
        .pclk(pclk), .reset_i(reset),
        .spi_sck_i(spi_sck_i), .spi_copi_i(spi_copi_i), .spi_cs_n_i(spi_cs_n_i),
        .transmit_byte_i(spi_transmit_byte), .spi_cipo_o(spi_cipo_o),
        .select_o(spi_select), .receive_strobe_o(spi_receive_strobe),
        .receive_byte_o(spi_receive_byte), .transmit_strobe_o()
    );

    spi_bus_bridge i_spi_bus_bridge (
        .pclk(pclk), .reset_i(reset), .select_i(spi_select),
        .receive_strobe_i(spi_receive_strobe), .receive_byte_i(spi_receive_byte),
        .bus_rdata_i(bus_rdata), .transmit_byte_o(spi_transmit_byte),
        .bus_cs_o(bus_cs), .bus_wr_o(bus_wr), .bus_bytesel_o(bus_bytesel),
        .bus_reg_num_o(bus_reg_num), .bus_wdata_o(bus_wdata)
    );

    xbus_regs i_xbus_regs (
        .pclk(pclk), .reset_i(reset), .bus_cs_i(bus_cs), .bus_wr_i(bus_wr),
        .bus_bytesel_i(bus_bytesel), .bus_reg_num_i(bus_reg_num),
        .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata),
        .audio_l_level_o(audio_l_level), .audio_r_level_o(audio_r_level)
    );

    audio_pwm i_audio_pwm (
        .pclk(pclk), .reset_i(reset),
        .level_l_i(audio_l_level), .level_r_i(audio_r_level),
        .audio_l_o(audio_l_o), .audio_r_o(audio_r_o)
    );

endmodule

`default_nettype wire

// ==== bench/xbus_spi_chk.sv ====
/*
 * bus strobe and reset assertions for the spi bus bridge
 */
`default_nettype none
`timescale 1ns/1ps

module xbus_spi_chk import xbus_pkg::*; (
    input wire           pclk,
    input wire           reset_i,
    input wire           bus_cs_i,
    input wire           receive_strobe_i,
    input bridge_state_t state_i
);

    int unsigned fail_count = 0;                // read by the testbench at the end

    cs_single_cycle: assert property (@(posedge pclk) disable iff (reset_i)
        bus_cs_i |=> !bus_cs_i)
        else begin
            fail_count++;
            $error("bus_cs held for more than one cycle");
        end

    cs_quiet_in_reset: assert property (@(posedge pclk) reset_i |-> !bus_cs_i)
        else begin
            fail_count++;
            $error("bus_cs raised during reset");
        end

    // strobe only after the data byte arrives
    cs_after_data_byte: assert property (@(posedge pclk) disable iff (reset_i)
        bus_cs_i |-> $past(receive_strobe_i) && $past(state_i) == BR_DATA)
        else begin
            fail_count++;
            $error("bus_cs without a data byte strobe in BR_DATA");
        end

endmodule

`default_nettype wire

// ==== bench/xbus_spi_tb.sv ====
/*
 * testbench for the spi register bus core
 * spi frame driver, register model with lcg stimulus, self-checking tests
 */
`default_nettype none
`timescale 1ns/1ps

module xbus_spi_tb import xbus_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 20000;     // ~100 frames of 144 cycles plus pwm windows

    logic        pclk = 1'b0;
    logic        rst_n, spi_sck, spi_copi, spi_cs_n;
    wire         spi_cipo, audio_l, audio_r, ready;
    word_t       ref_regs [16];                 // register model, follows every write
    int unsigned lcg_state = 77;
    int          got_q[$], exp_q[$];            // pending compares
    string       name_q[$];
    int          err_count = 0, err_mark = 0, check_count = 0;
    int          test_count = 0, test_fails = 0, cycle_count = 0;

    xbus_spi_top #(.RESET_CYCLES(RESET_CYCLES)) i_xbus_spi_top (
        .pclk(pclk), .rst_n_i(rst_n), .spi_sck_i(spi_sck), .spi_copi_i(spi_copi),
        .spi_cs_n_i(spi_cs_n), .spi_cipo_o(spi_cipo), .audio_l_o(audio_l),
        .audio_r_o(audio_r), .ready_o(ready)
    );

    bind spi_bus_bridge xbus_spi_chk i_bridge_chk (
        .pclk(pclk), .reset_i(reset_i), .bus_cs_i(bus_cs_o),
        .receive_strobe_i(receive_strobe_i), .state_i(state)
    );

    always #50 pclk = ~pclk;                    // 100 ns period

    always @(posedge pclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // compares everything queued since the last edge
    always @(posedge pclk) begin
        string name;
        int    got_v;
        int    exp_v;
        while (exp_q.size() > 0) begin
            name  = name_q.pop_front();
            got_v = got_q.pop_front();
            exp_v = exp_q.pop_front();
            check_count++;
            assert (got_v == exp_v) else begin
                $display("Fail at %0d ns: %s got %0h expected %0h", $time, name, got_v, exp_v);
                err_count++;
            end
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;                 // upper bits spread better
    endfunction

    function automatic byte_t ref_read(input reg_num_t num, input logic lane);
        return lane ? ref_regs[num][7:0] : ref_regs[num][15:8];    // lane 1 is low byte
    endfunction

    task automatic tick();
        @(posedge pclk);
        #10;                                    // drive point after the edge
    endtask

    task automatic expect_val(input string name, input int got, input int exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // mode-0 frame, 16 bits for a full frame or 8 for a command only
    task automatic spi_frame(input byte_t cmd, input byte_t data, input int nbits,
                             output byte_t first, output byte_t second);
        logic [15:0] tx_bits;
        logic [15:0] rx_bits;
        tx_bits  = {cmd, data};
        rx_bits  = '0;
        spi_cs_n = 1'b0;
        repeat (8) tick();                      // target loads the idle byte
        for (int i = 15; i >= 16 - nbits; i--) begin
            spi_copi = tx_bits[i];
            repeat (4) tick();
            rx_bits[i] = spi_cipo;              // sampled just before sck rises
            spi_sck = 1'b1;
            repeat (4) tick();
            spi_sck = 1'b0;
        end
        repeat (4) tick();
        spi_cs_n = 1'b1;
        repeat (4) tick();
        first  = rx_bits[15:8];
        second = rx_bits[7:0];
    endtask

    task automatic reg_write(input reg_num_t num, input logic lane, input byte_t data);
        byte_t first, second;
        spi_frame({1'b1, 2'b00, lane, num}, data, 16, first, second);
        expect_val("cipo first byte", first, SPI_IDLE_BYTE);
        if (lane) ref_regs[num][7:0] = data;
        else ref_regs[num][15:8] = data;
    endtask

    task automatic check_read(input reg_num_t num, input logic lane);
        byte_t first, second;
        spi_frame({1'b0, 2'b00, lane, num}, 8'h00, 16, first, second);
        expect_val("cipo first byte", first, SPI_IDLE_BYTE);
        expect_val($sformatf("cipo reg %0d lane %0d", num, lane), second, ref_read(num, lane));
    endtask

    task automatic finish_test(input string name);
        tick();                                 // queue drains at this edge
        test_count++;
        if (err_count != err_mark) test_fails++;
        $display("test %-10s %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin
        byte_t       first, second;
        byte_t       levels [3];
        int unsigned high_l, high_r;
        levels   = '{8'd0, 8'd64, 8'd255};
        rst_n    = 1'b0;
        spi_sck  = 1'b0;
        spi_copi = 1'b0;
        spi_cs_n = 1'b1;
        for (int i = 0; i < 16; i++) ref_regs[i] = '0;
        repeat (5) begin
            tick();
            expect_val("ready_o", ready, 0);
            expect_val("audio_l_o", audio_l, 0);
            expect_val("audio_r_o", audio_r, 0);
        end
        rst_n = 1'b1;
        for (int n = 1; n <= RESET_CYCLES + 2; n++) begin   // two sync cycles plus stretch
            tick();
            expect_val("ready_o", ready, n == RESET_CYCLES + 2);
            expect_val("audio_l_o", audio_l, 0);
            expect_val("audio_r_o", audio_r, 0);
        end
        finish_test("reset");
        check_read(4'd0, 1'b0);
        check_read(4'd15, 1'b1);
        finish_test("signature");
        for (int k = 0; k < 40; k++) begin
            reg_write(reg_num_t'(lcg_next() % 14), 1'(lcg_next()), byte_t'(lcg_next()));
            check_read(reg_num_t'(lcg_next() % 16), 1'(lcg_next()));
        end
        finish_test("write_read");
        reg_write(4'd7, 1'b0, 8'hA5);
        reg_write(4'd7, 1'b1, 8'h3C);
        reg_write(4'd7, 1'b0, 8'h5A);           // high lane only
        check_read(4'd7, 1'b1);
        check_read(4'd7, 1'b0);
        reg_write(4'd7, 1'b1, 8'hC3);           // low lane only
        check_read(4'd7, 1'b0);
        check_read(4'd7, 1'b1);
        finish_test("byte_lanes");
        reg_write(4'd3, 1'b1, 8'h69);           // known low lane before the abort
        check_read(4'd3, 1'b1);                 // leaves a zero data byte in the bridge
        spi_frame({1'b1, 2'b00, 1'b1, 4'd3}, 8'h00, 8, first, second);  // write, no data
        expect_val("cipo first byte", first, SPI_IDLE_BYTE);
        check_read(4'd3, 1'b1);
        check_read(4'd3, 1'b0);
        reg_write(4'd3, 1'b1, 8'h96);
        check_read(4'd3, 1'b1);
        finish_test("abort");
        for (int k = 0; k < 3; k++) begin
            reg_write(REG_AUDIO_L, 1'b1, levels[k]);
            reg_write(REG_AUDIO_R, 1'b1, levels[2 - k]);
            high_l = 0;
            high_r = 0;
            repeat (256) begin                  // one full ramp period
                tick();
                high_l += audio_l;
                high_r += audio_r;
            end
            expect_val("audio_l_o high cycles", high_l, levels[k]);
            expect_val("audio_r_o high cycles", high_r, levels[2 - k]);
        end
        finish_test("audio_pwm");
        err_count += i_xbus_spi_top.i_spi_bus_bridge.i_bridge_chk.fail_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fails, check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== xbus_spi_top.f ====
rtl/xbus_pkg.sv
rtl/reset_stretch.sv
rtl/spi_target.sv
rtl/spi_bus_bridge.sv
rtl/xbus_regs.sv
rtl/audio_pwm.sv
rtl/xbus_spi_top.sv
bench/xbus_spi_chk.sv
bench/xbus_spi_tb.sv

// ==== Makefile ====
# Verilator build and run of the spi register bus testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module xbus_spi_tb -f xbus_spi_top.f -o xbus_spi_sim
	./obj_dir/xbus_spi_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
